/* design/uniboard_pkg.sv */
package uniboard_pkg;

	// Clocks per serial bit, 1 Mbaud from the 12 MHz clock.
	localparam int baud_div = 12;

	// Width of the bit timing counters in both UART modules.
	localparam int baud_cnt_w = $clog2(baud_div);

	// Frame delimiters.
	localparam logic [7:0] byte_start = 8'h01;
	localparam logic [7:0] byte_end = 8'h17;

	// Makes the following byte literal.
	localparam logic [7:0] byte_escape = 8'h1B;

	// Payload bytes kept per command frame.
	localparam int payload_max = 6;

	// Counter width for the payload buffer fill level.
	localparam int payload_cnt_w = $clog2(payload_max + 1);

	// Register bus field widths.
	localparam int periph_w = 7;
	localparam int addr_w = 8;
	localparam int data_w = 32;
	localparam int size_w = 3;

	// Scratch register bank.
	localparam logic [periph_w-1:0] scratch_periph = 7'd1;
	localparam logic [size_w-1:0] scratch_size = 3'd4;
	localparam int scratch_depth = 4;

	// Address bits that select a scratch register.
	localparam int scratch_sel_w = $clog2(scratch_depth);

endpackage

/* design/uart_receiver.sv */
`timescale 1ns/1ns

module uart_receiver
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic rx,
	output logic [7:0] rx_data,
	output logic rx_valid
);

	typedef enum logic [1:0] {
		s_idle,
		s_start,
		s_data,
		s_stop
	} state_t;

	state_t state;
	logic rx_meta;
	logic rx_sync;
	logic [baud_cnt_w-1:0] baud_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] rx_shift;

	// Two flop synchronizer.
	// Idle line level is high.
	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= s_idle;
			baud_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			// Strobe lasts one cycle.
			rx_valid <= 1'b0;
			case (state)
				s_idle:
				begin
					baud_cnt <= '0;
					bit_cnt <= '0;
					// Falling edge marks a start bit.
					if (!rx_sync)
						state <= s_start;
				end
				s_start:
				begin
					// Recheck at mid start bit to reject glitches.
					if (baud_cnt == baud_cnt_w'(baud_div / 2 - 1))
					begin
						baud_cnt <= '0;
						state <= rx_sync ? s_idle : s_data;
					end
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				s_data:
				begin
					if (baud_cnt == baud_cnt_w'(baud_div - 1))
					begin
						// Mid-bit sample, LSB arrives first.
						baud_cnt <= '0;
						rx_shift <= {rx_sync, rx_shift[7:1]};
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= s_stop;
					end
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				s_stop:
				begin
					if (baud_cnt == baud_cnt_w'(baud_div - 1))
					begin
						// Byte only counts with a valid stop bit.
						baud_cnt <= '0;
						state <= s_idle;
						if (rx_sync)
						begin
							rx_data <= rx_shift;
							rx_valid <= 1'b1;
						end
					end
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				default:
					state <= s_idle;
			endcase
		end
	end

endmodule

/* design/uart_transmitter.sv */
`timescale 1ns/1ns

module uart_transmitter
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic [7:0] tx_data,
	input logic send,
	output logic tx,
	output logic busy
);

	logic [baud_cnt_w-1:0] baud_cnt;
	logic [3:0] bit_cnt;
	logic [8:0] frame;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			tx <= 1'b1;
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (!busy)
		begin
			baud_cnt <= '0;
			bit_cnt <= '0;
			if (send)
			begin
				// Data LSB first with the stop bit on top.
				// Start bit goes straight onto the line.
				frame <= {1'b1, tx_data};
				tx <= 1'b0;
				busy <= 1'b1;
			end
		end
		else if (baud_cnt == baud_cnt_w'(baud_div - 1))
		begin
			baud_cnt <= '0;
			if (bit_cnt == 4'd9)
			begin
				// Stop bit is over.
				busy <= 1'b0;
				tx <= 1'b1;
			end
			else
			begin
				// Next bit onto the line.
				bit_cnt <= bit_cnt + 1'b1;
				frame <= {1'b1, frame[8:1]};
				tx <= frame[0];
			end
		end
		else
			baud_cnt <= baud_cnt + 1'b1;
	end

endmodule

/* design/command_decoder.sv */
`timescale 1ns/1ns

module command_decoder
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic [7:0] rx_data,
	input logic rx_valid,
	input logic busy,
	output logic cmd_valid,
	output logic cmd_read,
	output logic [periph_w-1:0] cmd_periph,
	output logic [addr_w-1:0] cmd_addr,
	output logic [data_w-1:0] cmd_wdata
);

	typedef enum logic {
		s_hunt,
		s_frame
	} state_t;

	state_t state;
	logic escape;
	logic [payload_cnt_w-1:0] byte_cnt;
	logic [7:0] payload [payload_max];
	logic is_start;
	logic is_end;
	logic is_escape;
	logic clear_buf;
	logic store_byte;
	logic issue;

	assign is_start = (rx_data == byte_start);
	assign is_end = (rx_data == byte_end);
	assign is_escape = (rx_data == byte_escape);

	// Classify each received byte.
	// An escaped byte is always data.
	always_comb
	begin
		clear_buf = 1'b0;
		store_byte = 1'b0;
		if (rx_valid)
		begin
			if (state == s_hunt)
				clear_buf = is_start;
			else if (escape)
				store_byte = 1'b1;
			else if (is_start)
				clear_buf = 1'b1;
			else if (!is_end && !is_escape)
				store_byte = 1'b1;
		end
	end

	// Complete frame needs peripheral and address bytes.
	// Dropped if the sequencer is still working.
	assign issue = rx_valid && (state == s_frame) && !escape && is_end &&
		(byte_cnt >= payload_cnt_w'(2)) && !busy;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= s_hunt;
			escape <= 1'b0;
			byte_cnt <= '0;
			cmd_valid <= 1'b0;
		end
		else
		begin
			cmd_valid <= issue;
			if (clear_buf)
			begin
				// Start byte opens or restarts a frame.
				state <= s_frame;
				escape <= 1'b0;
				byte_cnt <= '0;
			end
			else if (store_byte)
			begin
				escape <= 1'b0;
				// Extra payload bytes are ignored.
				if (byte_cnt < payload_cnt_w'(payload_max))
					byte_cnt <= byte_cnt + 1'b1;
			end
			else if (rx_valid && (state == s_frame))
			begin
				if (is_escape)
					escape <= 1'b1;
				else
					state <= s_hunt;
			end
		end
	end

	// Payload buffer.
	// Missing write data bytes stay zero.
	always_ff @(posedge clk_12MHz)
	begin
		if (clear_buf)
		begin
			for (int i = 0; i < payload_max; i++)
				payload[i] <= '0;
		end
		else if (store_byte && (byte_cnt < payload_cnt_w'(payload_max)))
			payload[byte_cnt] <= rx_data;
	end

	// Command fields, held until the next command.
	always_ff @(posedge clk_12MHz)
	begin
		if (issue)
		begin
			cmd_read <= payload[0][7];
			cmd_periph <= payload[0][periph_w-1:0];
			cmd_addr <= payload[1];
			// Write data arrives LSB first.
			cmd_wdata <= {payload[5], payload[4], payload[3], payload[2]};
		end
	end

endmodule

/* design/bus_sequencer.sv */
`timescale 1ns/1ns

module bus_sequencer
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic cmd_valid,
	input logic cmd_read,
	input logic [periph_w-1:0] cmd_periph,
	input logic [addr_w-1:0] cmd_addr,
	input logic [data_w-1:0] cmd_wdata,
	input logic encoder_busy,
	output logic busy,
	output logic bus_rw,
	output logic [periph_w-1:0] bus_periph,
	output logic [addr_w-1:0] bus_addr,
	output logic [data_w-1:0] bus_wdata,
	output logic bus_select,
	input logic [data_w-1:0] bus_rdata,
	input logic [size_w-1:0] bus_size,
	output logic reply_valid,
	output logic [periph_w:0] reply_periph_byte,
	output logic [addr_w-1:0] reply_addr,
	output logic [data_w-1:0] reply_data,
	output logic [size_w-1:0] reply_size
);

	typedef enum logic [3:0] {
		s_idle,
		s_wr_setup,
		s_wr_sel,
		s_wr_hold,
		s_wr_gap,
		s_wr_rest,
		s_rd_setup,
		s_rd_sel,
		s_rd_wait,
		s_reply,
		s_encode
	} state_t;

	state_t state;
	logic read_flag;

	// Covers the bus cycles and the reply transmission.
	assign busy = (state != s_idle) || encoder_busy;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= s_idle;
			bus_rw <= 1'b1;
			bus_select <= 1'b0;
			reply_valid <= 1'b0;
		end
		else
		begin
			reply_valid <= 1'b0;
			case (state)
				s_idle:
				begin
					// Reads skip straight to the read sequence.
					if (cmd_valid)
					begin
						bus_rw <= cmd_read;
						state <= cmd_read ? s_rd_setup : s_wr_setup;
					end
				end
				s_wr_setup:
				begin
					bus_select <= 1'b1;
					state <= s_wr_sel;
				end
				s_wr_sel:
					state <= s_wr_hold;
				s_wr_hold:
				begin
					// Select was high for two cycles.
					bus_select <= 1'b0;
					state <= s_wr_gap;
				end
				s_wr_gap:
					state <= s_wr_rest;
				s_wr_rest:
				begin
					// Read back what was written.
					bus_rw <= 1'b1;
					state <= s_rd_setup;
				end
				s_rd_setup:
				begin
					bus_select <= 1'b1;
					state <= s_rd_sel;
				end
				s_rd_sel:
					state <= s_rd_wait;
				s_rd_wait:
				begin
					// Data is settled, capture and hand off.
					bus_select <= 1'b0;
					reply_valid <= 1'b1;
					state <= s_reply;
				end
				s_reply:
					state <= s_encode;
				s_encode:
				begin
					if (!encoder_busy)
						state <= s_idle;
				end
				default:
					state <= s_idle;
			endcase
		end
	end

	// Bus fields and reply capture.
	always_ff @(posedge clk_12MHz)
	begin
		if ((state == s_idle) && cmd_valid)
		begin
			read_flag <= cmd_read;
			bus_periph <= cmd_periph;
			bus_addr <= cmd_addr;
			bus_wdata <= cmd_wdata;
		end
		if (state == s_rd_wait)
		begin
			// Echo the original first payload byte.
			reply_periph_byte <= {read_flag, bus_periph};
			reply_addr <= bus_addr;
			reply_data <= bus_rdata;
			reply_size <= bus_size;
		end
	end

endmodule

/* design/reply_encoder.sv */
`timescale 1ns/1ns

module reply_encoder
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic reply_valid,
	input logic [periph_w:0] reply_periph_byte,
	input logic [addr_w-1:0] reply_addr,
	input logic [data_w-1:0] reply_data,
	input logic [size_w-1:0] reply_size,
	input logic tx_busy,
	output logic [7:0] tx_data,
	output logic send,
	output logic busy
);

	typedef enum logic [1:0] {
		s_idle,
		s_load,
		s_send,
		s_wait
	} state_t;

	typedef logic [size_w:0] idx_t;

	state_t state;
	logic [periph_w:0] periph_q;
	logic [addr_w-1:0] addr_q;
	logic [data_w-1:0] data_q;
	logic [size_w-1:0] size_q;
	idx_t idx;
	idx_t end_idx;
	idx_t data_idx;
	logic [data_w-1:0] data_shifted;
	logic [7:0] cur_byte;
	logic special;
	logic esc_sent;

	// Byte order is start, byte 0, address, data, end.
	assign end_idx = {1'b0, size_q} + idx_t'(3);
	assign data_idx = idx - idx_t'(3);
	assign data_shifted = data_q >> {data_idx, 3'b000};

	always_comb
	begin
		if (idx == idx_t'(0))
			cur_byte = byte_start;
		else if (idx == idx_t'(1))
			cur_byte = periph_q;
		else if (idx == idx_t'(2))
			cur_byte = addr_q;
		else if (idx == end_idx)
			cur_byte = byte_end;
		else
			cur_byte = data_shifted[7:0];
	end

	// Delimiters go out raw, everything else is escaped if special.
	assign special = (idx != idx_t'(0)) && (idx != end_idx) &&
		((cur_byte == byte_start) || (cur_byte == byte_end) || (cur_byte == byte_escape));

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= s_idle;
			idx <= '0;
			esc_sent <= 1'b0;
			send <= 1'b0;
			busy <= 1'b0;
		end
		else
		begin
			case (state)
				s_idle:
				begin
					if (reply_valid)
					begin
						busy <= 1'b1;
						idx <= '0;
						esc_sent <= 1'b0;
						state <= s_load;
					end
				end
				s_load:
				begin
					if (idx > end_idx)
					begin
						// End byte has left the transmitter.
						busy <= 1'b0;
						state <= s_idle;
					end
					else
					begin
						send <= 1'b1;
						state <= s_send;
						// Stay on this byte until its escape is out.
						if (special && !esc_sent)
							esc_sent <= 1'b1;
						else
						begin
							esc_sent <= 1'b0;
							idx <= idx + 1'b1;
						end
					end
				end
				s_send:
				begin
					// Transmitter took the byte.
					if (tx_busy)
					begin
						send <= 1'b0;
						state <= s_wait;
					end
				end
				s_wait:
				begin
					if (!tx_busy)
						state <= s_load;
				end
				default:
					state <= s_idle;
			endcase
		end
	end

	// Reply fields and the outgoing byte.
	always_ff @(posedge clk_12MHz)
	begin
		if ((state == s_idle) && reply_valid)
		begin
			periph_q <= reply_periph_byte;
			addr_q <= reply_addr;
			data_q <= reply_data;
			size_q <= reply_size;
		end
		if ((state == s_load) && (idx <= end_idx))
			tx_data <= (special && !esc_sent) ? byte_escape : cur_byte;
	end

endmodule

/* design/register_bank.sv */
`timescale 1ns/1ns

module register_bank
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic bus_rw,
	input logic [periph_w-1:0] bus_periph,
	input logic [addr_w-1:0] bus_addr,
	input logic [data_w-1:0] bus_wdata,
	input logic bus_select,
	output logic [data_w-1:0] bus_rdata,
	output logic [size_w-1:0] bus_size
);

	logic [data_w-1:0] scratch [scratch_depth];
	logic select_q;
	logic hit;
	logic [scratch_sel_w-1:0] sel;

	// Scratch bank decode.
	assign hit = (bus_periph == scratch_periph);
	assign sel = bus_addr[scratch_sel_w-1:0];

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			select_q <= 1'b0;
			for (int i = 0; i < scratch_depth; i++)
				scratch[i] <= '0;
		end
		else
		begin
			select_q <= bus_select;
			// Write on the rising edge of select.
			if (bus_select && !select_q && !bus_rw && hit)
				scratch[sel] <= bus_wdata;
		end
	end

	// Read multiplexer.
	// Unmapped peripherals answer zero with no data bytes.
	always_comb
	begin
		bus_rdata = '0;
		bus_size = '0;
		if (bus_select && hit)
		begin
			bus_rdata = scratch[sel];
			bus_size = scratch_size;
		end
	end

endmodule

/* design/uniboard_top.sv */
`timescale 1ns/1ns

module uniboard_top
	import uniboard_pkg::*;
(
	input logic clk_12MHz,
	input logic reset,
	input logic uart_rx,
	output logic uart_tx
);

	// Receiver to decoder.
	logic [7:0] rx_data;
	logic rx_valid;

	// Decoder to sequencer.
	logic cmd_valid;
	logic cmd_read;
	logic [periph_w-1:0] cmd_periph;
	logic [addr_w-1:0] cmd_addr;
	logic [data_w-1:0] cmd_wdata;
	logic seq_busy;

	// Register bus.
	logic bus_rw;
	logic [periph_w-1:0] bus_periph;
	logic [addr_w-1:0] bus_addr;
	logic [data_w-1:0] bus_wdata;
	logic bus_select;
	logic [data_w-1:0] bus_rdata;
	logic [size_w-1:0] bus_size;

	// Sequencer to encoder.
	logic reply_valid;
	logic [periph_w:0] reply_periph_byte;
	logic [addr_w-1:0] reply_addr;
	logic [data_w-1:0] reply_data;
	logic [size_w-1:0] reply_size;
	logic encoder_busy;

	// Encoder to transmitter.
	logic [7:0] tx_data;
	logic send;
	logic tx_busy;

	uart_receiver u_receiver (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.rx(uart_rx),
		.rx_data(rx_data),
		.rx_valid(rx_valid)
	);

	command_decoder u_decoder (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.busy(seq_busy),
		.cmd_valid(cmd_valid),
		.cmd_read(cmd_read),
		.cmd_periph(cmd_periph),
		.cmd_addr(cmd_addr),
		.cmd_wdata(cmd_wdata)
	);

	bus_sequencer u_sequencer (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_read(cmd_read),
		.cmd_periph(cmd_periph),
		.cmd_addr(cmd_addr),
		.cmd_wdata(cmd_wdata),
		.encoder_busy(encoder_busy),
		.busy(seq_busy),
		.bus_rw(bus_rw),
		.bus_periph(bus_periph),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus_select(bus_select),
		.bus_rdata(bus_rdata),
		.bus_size(bus_size),
		.reply_valid(reply_valid),
		.reply_periph_byte(reply_periph_byte),
		.reply_addr(reply_addr),
		.reply_data(reply_data),
		.reply_size(reply_size)
	);

	register_bank u_bank (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.bus_rw(bus_rw),
		.bus_periph(bus_periph),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus_select(bus_select),
		.bus_rdata(bus_rdata),
		.bus_size(bus_size)
	);

	reply_encoder u_encoder (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.reply_valid(reply_valid),
		.reply_periph_byte(reply_periph_byte),
		.reply_addr(reply_addr),
		.reply_data(reply_data),
		.reply_size(reply_size),
		.tx_busy(tx_busy),
		.tx_data(tx_data),
		.send(send),
		.busy(encoder_busy)
	);

	uart_transmitter u_transmitter (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.tx_data(tx_data),
		.send(send),
		.tx(uart_tx),
		.busy(tx_busy)
	);

endmodule

/* testbench/tb_uniboard.sv */
`timescale 1ns/1ns

module tb_uniboard
	import uniboard_pkg::*;
();

	// Quiet time after a reply, long enough for a stray extra byte.
	localparam int guard_cycles = 2 * 11 * baud_div;

	logic clk_12MHz;
	logic reset;
	logic uart_rx;
	logic uart_tx;

	// Cases from the data file, flattened into byte pools.
	string case_names[$];
	int send_first[$];
	int send_count[$];
	int exp_first[$];
	int exp_count[$];
	logic [7:0] send_pool[$];
	logic [7:0] exp_pool[$];

	// Bytes seen on uart_tx.
	logic [7:0] reply_bytes[$];
	int tx_frame_errors;

	int case_errors;
	int check_errors;
	int pass_count;
	int fail_count;
	int cycle_count;
	int cycle_limit;
	bit limit_ready;

	uniboard_top u_uniboard_top (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx)
	);

	// Free running clock with a 40 ns period.
	initial
	begin
		clk_12MHz = 1'b0;
		forever
			#20 clk_12MHz = ~clk_12MHz;
	end

	// Compares one value and reports a mismatch.
	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
			case_errors++;
		end
	endtask

	// Reads name, send bytes and reply bytes per line.
	task automatic load_cases(output bit ok);
		int fd;
		int n;
		int cnt;
		int val;
		int code;
		bit bad;
		string tok;
		string rest;
		ok = 1'b0;
		bad = 1'b0;
		fd = $fopen("testbench/uniboard_cases.txt", "r");
		if (fd != 0)
		begin
			while ($fscanf(fd, "%s", tok) == 1)
			begin
				if (tok.substr(0, 0) == "#")
					code = $fgets(rest, fd);
				else
				begin
					case_names.push_back(tok);
					code = $fscanf(fd, "%d", cnt);
					if (code != 1)
						bad = 1'b1;
					send_first.push_back(send_pool.size());
					send_count.push_back(cnt);
					for (n = 0; n < cnt; n++)
					begin
						code = $fscanf(fd, "%h", val);
						if (code != 1)
							bad = 1'b1;
						send_pool.push_back(val[7:0]);
					end
					code = $fscanf(fd, "%d", cnt);
					if (code != 1)
						bad = 1'b1;
					exp_first.push_back(exp_pool.size());
					exp_count.push_back(cnt);
					for (n = 0; n < cnt; n++)
					begin
						code = $fscanf(fd, "%h", val);
						if (code != 1)
							bad = 1'b1;
						exp_pool.push_back(val[7:0]);
					end
				end
			end
			$fclose(fd);
			ok = !bad && (case_names.size() > 0);
		end
	endtask

	// One byte on uart_rx, then one idle bit.
	// Called right after a rising edge.
	task automatic send_byte(input logic [7:0] value);
		logic [9:0] frame;
		int i;
		frame = {1'b1, value, 1'b0};
		for (i = 0; i < 10; i++)
		begin
			uart_rx <= frame[i];
			repeat (baud_div) @(posedge clk_12MHz);
		end
		repeat (baud_div) @(posedge clk_12MHz);
	endtask

	// Sends one case and checks the reply that comes back.
	task automatic run_case(input int c);
		int i;
		int waited;
		int limit;
		int got_n;
		int exp_n;
		int frame_errors_before;
		case_errors = 0;
		reply_bytes.delete();
		frame_errors_before = tx_frame_errors;
		exp_n = exp_count[c];
		limit = (send_count[c] + exp_n) * 11 * baud_div * 2;
		for (i = 0; i < send_count[c]; i++)
			send_byte(send_pool[send_first[c] + i]);
		// Reply is complete once all expected bytes arrived.
		waited = 0;
		while ((reply_bytes.size() < exp_n) && (waited < limit))
		begin
			@(posedge clk_12MHz);
			waited++;
		end
		repeat (guard_cycles) @(posedge clk_12MHz);
		got_n = reply_bytes.size();
		for (i = 0; (i < exp_n) && (i < got_n); i++)
			check_value($sformatf("uart_tx byte %0d", i), reply_bytes[i],
				exp_pool[exp_first[c] + i]);
		if (got_n < exp_n)
		begin
			$display("%s: reply stopped after %0d of %0d bytes", case_names[c], got_n, exp_n);
			case_errors++;
		end
		else if (got_n > exp_n)
		begin
			$display("%s: %0d bytes more than the expected reply", case_names[c], got_n - exp_n);
			case_errors++;
		end
		if (tx_frame_errors != frame_errors_before)
		begin
			$display("%s: reply byte had a low stop bit", case_names[c]);
			case_errors++;
		end
		check_errors += case_errors;
		if (case_errors == 0)
		begin
			pass_count++;
			$display("PASS %s", case_names[c]);
		end
		else
		begin
			fail_count++;
			$display("FAIL %s with %0d errors", case_names[c], case_errors);
		end
	endtask

	// Serial monitor on uart_tx.
	initial
	begin
		logic [7:0] value;
		int i;
		tx_frame_errors = 0;
		forever
		begin
			@(posedge clk_12MHz);
			if (!reset && (uart_tx === 1'b0))
			begin
				// Move to mid start bit, then mid of each data bit.
				repeat (baud_div / 2) @(posedge clk_12MHz);
				for (i = 0; i < 8; i++)
				begin
					repeat (baud_div) @(posedge clk_12MHz);
					value[i] = uart_tx;
				end
				repeat (baud_div) @(posedge clk_12MHz);
				if (uart_tx !== 1'b1)
					tx_frame_errors++;
				reply_bytes.push_back(value);
			end
		end
	end

	// Run limit from the total traffic of all cases.
	initial
	begin
		cycle_count = 0;
		wait (limit_ready);
		while (cycle_count < cycle_limit)
		begin
			@(posedge clk_12MHz);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the run was stopped", cycle_count);
		$display("test failed");
		$finish;
	end

	initial
	begin
		bit ok;
		int c;
		int total_bytes;
		reset <= 1'b1;
		uart_rx <= 1'b1;
		limit_ready = 1'b0;
		check_errors = 0;
		pass_count = 0;
		fail_count = 0;
		load_cases(ok);
		if (!ok)
		begin
			$display("Case file could not be read, is malformed or holds no cases");
			$display("test failed");
			$finish;
		end
		else
		begin
			total_bytes = send_pool.size() + exp_pool.size();
			cycle_limit = total_bytes * 11 * baud_div * 2 + 2000;
			limit_ready = 1'b1;
			// Reset for 16 cycles, then let the line idle.
			repeat (16) @(posedge clk_12MHz);
			reset <= 1'b0;
			repeat (4) @(posedge clk_12MHz);
			for (c = 0; c < case_names.size(); c++)
				run_case(c);
			$display("%0d tests, %0d passed, %0d failed, %0d check errors",
				case_names.size(), pass_count, fail_count, check_errors);
			if (fail_count == 0)
				$display("test passed");
			else
				$display("test failed");
			$finish;
		end
	end

endmodule

/* testbench/uniboard_cases.txt */
# name  send_count  send_bytes (hex, as on the wire)  reply_count  reply_bytes (hex)
# Counts are decimal. Each case waits for its reply before the next one starts.
# Reads of every scratch register right after reset.
read_reg0 4 01 81 00 17 8 01 81 00 00 00 00 00 17
read_reg1 5 01 81 1B 01 17 9 01 81 1B 01 00 00 00 00 17
read_reg2 4 01 81 02 17 8 01 81 02 00 00 00 00 17
read_reg3 4 01 81 03 17 8 01 81 03 00 00 00 00 17
# Write to register 2, read back, register 3 untouched.
write_reg2 9 01 1B 01 02 72 4E C3 A5 17 9 01 1B 01 02 72 4E C3 A5 17
read_reg2_back 4 01 81 02 17 8 01 81 02 72 4E C3 A5 17
read_reg3_zero 4 01 81 03 17 8 01 81 03 00 00 00 00 17
# Unmapped peripheral 5 answers with no data bytes.
read_periph5 4 01 85 10 17 4 01 85 10 17
write_periph5 8 01 05 20 11 22 33 44 17 4 01 05 20 17
# Data bytes equal to the framing bytes, escaped both ways.
write_reg0_special 12 01 1B 01 00 1B 01 1B 17 1B 1B 5A 17 12 01 1B 01 00 1B 01 1B 17 1B 1B 5A 17
read_reg0_special 4 01 81 00 17 11 01 81 00 1B 01 1B 17 1B 1B 5A 17
# One payload byte is dropped, the read after it is answered.
short_frame_then_read 7 01 81 17 01 81 02 17 8 01 81 02 72 4E C3 A5 17
# A start byte restarts the frame, only the second frame counts.
restart_frame 9 01 1B 01 00 AA 01 81 03 17 8 01 81 03 00 00 00 00 17
read_reg0_unchanged 4 01 81 00 17 11 01 81 00 1B 01 1B 17 1B 1B 5A 17
# Missing data bytes count as zero.
write_reg1_short 8 01 1B 01 1B 01 34 12 17 10 01 1B 01 1B 01 34 12 00 00 17
# Payload bytes after the sixth are ignored.
write_reg3_long 11 01 1B 01 03 11 22 33 44 55 66 17 9 01 1B 01 03 11 22 33 44 17

/* vlog.f */
design/uniboard_pkg.sv
design/uart_receiver.sv
design/uart_transmitter.sv
design/command_decoder.sv
design/bus_sequencer.sv
design/reply_encoder.sv
design/register_bank.sv
design/uniboard_top.sv
testbench/tb_uniboard.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f vlog.f --top-module tb_uniboard -Mdir obj_dir -o tb_uniboard \
	&& ./obj_dir/tb_uniboard | tee sim.log \
	|| { echo "Build or run error"; exit 1; }
grep -qx "test passed" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
